//--- verilog/sys_bus_pkg.sv
// System bus shared types

package sys_bus_pkg;

   // ------------------------------
   // axi response codes

   typedef enum logic [1:0] {
      OKAY   = 2'b00,   // normal access
      SLVERR = 2'b10    // bridge-generated error
   } axi_resp_e;

   // ------------------------------
   // address regions

   // only the two banks are mapped, every other code is a hole
   typedef enum logic [3:0] {
      BANK_A = 4'd0,
      BANK_B = 4'd1
   } region_e;

   // ------------------------------
   // address word layout

   typedef struct packed {
      logic [3:0]  region;   // top nibble picks the bank
      logic [23:0] unused;   // ignored by all slaves
      logic [1:0]  index;    // register index in a bank
      logic [1:0]  offset;   // byte offset, word access only
   } sys_addr_fields_t;

   // same 32 bits, raw or split into fields
   typedef union packed {
      logic [31:0]      raw;     // as seen on the axi side
      sys_addr_fields_t field;   // as used by decoder and banks
   } sys_addr_u;

endpackage

//--- verilog/sys_bus_if.sv
// System register bus

interface sys_bus_if import sys_bus_pkg::*; ();

   sys_addr_u   addr;    // valid with a strobe
   logic [31:0] wdata;   // write payload
   logic        wen;     // one-cycle write strobe
   logic        ren;     // one-cycle read strobe
   logic [31:0] rdata;   // valid with ack of a read
   logic        ack;     // one-cycle done pulse

   // requester side
   modport m (
      output addr,
      output wdata,
      output wen,
      output ren,
      input  rdata,
      input  ack
   );

   // responder side
   modport s (
      input  addr,
      input  wdata,
      input  wen,
      input  ren,
      output rdata,
      output ack
   );

endinterface

//--- verilog/axi_sys_bridge.sv
// AXI to system bus bridge

module axi_sys_bridge import sys_bus_pkg::*; #(
   parameter int ID_W        = 8,
   parameter int ACK_TIMEOUT = 32
) (
   input  logic            axi,
   input  logic            reset,
   // write address
   input  logic [ID_W-1:0] awid,
   input  logic [31:0]     awaddr,
   input  logic [3:0]      awlen,
   input  logic [2:0]      awsize,
   input  logic            awvalid,
   output logic            awready,
   // write data
   input  logic [ID_W-1:0] wid,
   input  logic [31:0]     wdata,
   input  logic            wvalid,
   output logic            wready,
   // write response
   output logic [ID_W-1:0] bid,
   output axi_resp_e       bresp,
   output logic            bvalid,
   input  logic            bready,
   // read address
   input  logic [ID_W-1:0] arid,
   input  logic [31:0]     araddr,
   input  logic [3:0]      arlen,
   input  logic [2:0]      arsize,
   input  logic            arvalid,
   output logic            arready,
   // read data
   output logic [ID_W-1:0] rid,
   output logic [31:0]     rdata,
   output axi_resp_e       rresp,
   output logic            rlast,
   output logic            rvalid,
   input  logic            rready,
   // system bus
   sys_bus_if.m            bus
);

   localparam int CNT_W = $clog2(ACK_TIMEOUT) + 1;

   logic             wr_busy;    // write accepted, until b handshake
   logic             rd_busy;    // read accepted, until r handshake
   logic             w_done;     // write data taken
   logic             wr_err;     // latched burst/size error
   logic             rd_err;
   logic             err_go;     // self ack for bad transfers
   logic [ID_W-1:0]  wr_id;
   logic [ID_W-1:0]  rd_id;
   sys_addr_u        addr_q;
   logic [31:0]      wdata_q;
   logic             cnt_run;
   logic [CNT_W-1:0] ack_cnt;
   logic             cnt_en;
   logic             tmo_hit;
   logic             aw_hs;
   logic             w_hs;
   logic             ar_hs;
   logic             aw_bad;
   logic             ar_bad;
   logic             ack_any;
   logic             wr_ack;
   logic             rd_ack;

   // ------------------------------
   // channel arbitration

   assign aw_bad  = (awlen != 4'd0) || (awsize != 3'b010);   // burst or not 4 bytes
   assign ar_bad  = (arlen != 4'd0) || (arsize != 3'b010);
   assign awready = !wr_busy && !rd_busy;                     // idle
   assign arready = !wr_busy && !rd_busy && !awvalid;         // write wins
   assign wready  = wr_busy && !w_done && wvalid;
   assign aw_hs   = awvalid && awready;
   assign w_hs    = wvalid && wready;
   assign ar_hs   = arvalid && arready;

   always_ff @(posedge axi) begin
      if (reset) begin
         wr_busy <= 1'b0;
         rd_busy <= 1'b0;
         w_done  <= 1'b0;
         wr_err  <= 1'b0;
         rd_err  <= 1'b0;
      end else begin
         if (aw_hs) begin
            wr_busy <= 1'b1;
            w_done  <= 1'b0;
            wr_err  <= aw_bad;
         end else if (bvalid && bready) begin
            wr_busy <= 1'b0;                 // back to idle
         end
         if (w_hs) w_done <= 1'b1;
         if (ar_hs) begin
            rd_busy <= 1'b1;
            rd_err  <= ar_bad;
         end else if (rvalid && rready) begin
            rd_busy <= 1'b0;
         end
      end
   end

   always_ff @(posedge axi) begin
      if (aw_hs) begin
         wr_id      <= awid;
         addr_q.raw <= awaddr;
      end
      if (ar_hs) begin
         rd_id      <= arid;
         addr_q.raw <= araddr;              // never same cycle as aw
      end
      if (w_hs) wdata_q <= wdata;
   end

   // ------------------------------
   // system bus strobes

   always_ff @(posedge axi) begin
      if (reset) begin
         bus.wen <= 1'b0;
         bus.ren <= 1'b0;
         err_go  <= 1'b0;
      end else begin
         bus.wen <= w_hs && !wr_err;        // cycle after w handshake
         bus.ren <= ar_hs && !ar_bad;       // cycle after ar handshake
         err_go  <= (w_hs && wr_err) || (ar_hs && ar_bad);
      end
   end

   assign bus.addr  = addr_q;
   assign bus.wdata = wdata_q;

   // ------------------------------
   // ack timeout

   // a write waiting for its data does not age
   assign cnt_en  = cnt_run && !(wr_busy && !w_done);
   assign tmo_hit = cnt_en && (ack_cnt == CNT_W'(ACK_TIMEOUT - 1)) && !bus.ack;
   assign ack_any = bus.ack || err_go || tmo_hit;

   always_ff @(posedge axi) begin
      if (reset) begin
         cnt_run <= 1'b0;
         ack_cnt <= '0;
      end else if (aw_hs || ar_hs) begin
         cnt_run <= 1'b1;                   // restart per transfer
         ack_cnt <= '0;
      end else if (ack_any) begin
         cnt_run <= 1'b0;
      end else if (cnt_en) begin
         ack_cnt <= ack_cnt + 1'b1;
      end
   end

   // ------------------------------
   // held responses

   assign wr_ack = wr_busy && w_done && !bvalid && ack_any;
   assign rd_ack = rd_busy && !rvalid && ack_any;

   always_ff @(posedge axi) begin
      if (reset) begin
         bvalid <= 1'b0;
         rvalid <= 1'b0;
      end else begin
         if (wr_ack) bvalid <= 1'b1;
         else if (bready) bvalid <= 1'b0;   // held until taken
         if (rd_ack) rvalid <= 1'b1;
         else if (rready) rvalid <= 1'b0;
      end
   end

   always_ff @(posedge axi) begin
      if (wr_ack) bresp <= (wr_err || tmo_hit) ? SLVERR : OKAY;
      if (rd_ack) begin
         rresp <= (rd_err || tmo_hit) ? SLVERR : OKAY;
         rdata <= (rd_err || tmo_hit) ? 32'h0 : bus.rdata;
      end
   end

   assign bid   = wr_id;    // echo latched ids
   assign rid   = rd_id;
   assign rlast = rvalid;   // single beat only

   // ------------------------------
   // checks

   strobe_excl: assert property (@(posedge axi) disable iff (reset)
      !(bus.wen && bus.ren));
   resp_order: assert property (@(posedge axi) disable iff (reset)
      rvalid |-> !$rose(bvalid));
   // axi3 wid must follow the accepted awid
   wid_match: assert property (@(posedge axi) disable iff (reset)
      w_hs |-> (wid == wr_id));

endmodule

//--- verilog/sys_bus_decoder.sv
// System bus region decoder

module sys_bus_decoder import sys_bus_pkg::*; (
   input  logic axi,
   input  logic reset,
   sys_bus_if.s host,     // from the bridge
   sys_bus_if.m bank_a,   // region 0
   sys_bus_if.m bank_b    // region 1
);

   logic       hit_a;
   logic       hit_b;
   logic [3:0] region_q;   // region of the last strobe

   // ------------------------------
   // strobe routing

   assign hit_a = (host.addr.field.region == BANK_A);
   assign hit_b = (host.addr.field.region == BANK_B);

   assign bank_a.addr  = host.addr;
   assign bank_a.wdata = host.wdata;
   assign bank_a.wen   = host.wen && hit_a;   // gated per region
   assign bank_a.ren   = host.ren && hit_a;

   assign bank_b.addr  = host.addr;
   assign bank_b.wdata = host.wdata;
   assign bank_b.wen   = host.wen && hit_b;
   assign bank_b.ren   = host.ren && hit_b;

   // unmapped codes reach no bank, so the bridge times out

   // ------------------------------
   // return path

   always_ff @(posedge axi) begin
      if (reset) begin
         region_q <= 4'hf;                    // nothing selected
      end else if (host.wen || host.ren) begin
         region_q <= host.addr.field.region;  // hold until next strobe
      end
   end

   assign host.ack   = (region_q == BANK_A) ? bank_a.ack :
                       (region_q == BANK_B) ? bank_b.ack :
                                              1'b0;
   assign host.rdata = (region_q == BANK_A) ? bank_a.rdata :
                       (region_q == BANK_B) ? bank_b.rdata :
                                              32'h0;

   // ------------------------------
   // checks

   // delays differ, but only one transfer is ever in flight
   ack_excl: assert property (@(posedge axi) disable iff (reset)
      !(bank_a.ack && bank_b.ack));

endmodule

//--- verilog/reg_bank.sv
// Register bank with ID word

module reg_bank import sys_bus_pkg::*; #(
   parameter logic [31:0] BANK_ID   = 32'h0,
   parameter int          ACK_DELAY = 0
) (
   input  logic axi,
   input  logic reset,
   sys_bus_if.s bus
);

   localparam int SR_W = ACK_DELAY + 1;

   sys_addr_u   req;             // decoded view of the bus address
   logic [31:0] regs [1:3];      // index 0 is the id word
   logic [31:0] rdata_q;
   logic [SR_W-1:0] ack_sr;      // strobe delay line
   logic        strobe;

   assign req    = bus.addr;
   assign strobe = bus.wen || bus.ren;

   // ------------------------------
   // register file

   always_ff @(posedge axi) begin
      if (reset) begin
         regs[1] <= 32'h0;
         regs[2] <= 32'h0;
         regs[3] <= 32'h0;
      end else if (bus.wen && (req.field.index != 2'd0)) begin
         regs[req.field.index] <= bus.wdata;   // id word is read only
      end
   end

   always_ff @(posedge axi) begin
      if (bus.ren) begin
         if (req.field.index == 2'd0) begin
            rdata_q <= BANK_ID;
         end else begin
            rdata_q <= regs[req.field.index];
         end
      end
   end

   // ------------------------------
   // acknowledge

   always_ff @(posedge axi) begin
      if (reset) begin
         ack_sr <= '0;
      end else begin
         ack_sr <= (ack_sr << 1) | SR_W'(strobe);   // 1 + ACK_DELAY stages
      end
   end

   assign bus.ack   = ack_sr[SR_W-1];
   assign bus.rdata = rdata_q;          // stable from ack on

   // ------------------------------
   // checks

   ack_cause: assert property (@(posedge axi) disable iff (reset)
      $rose(bus.ack) |-> $past(strobe, ACK_DELAY + 1));

endmodule

//--- verilog/axi_sys_top.sv
// AXI register subsystem top

module axi_sys_top import sys_bus_pkg::*; #(
   parameter int          ID_W        = 8,
   parameter int          ACK_TIMEOUT = 32,
   parameter logic [31:0] BANK_A_ID   = {28'hba5e_00a, BANK_A},   // low nibble is region
   parameter logic [31:0] BANK_B_ID   = {28'hba5e_00b, BANK_B}
) (
   input  logic            axi,
   input  logic            reset,
   input  logic [ID_W-1:0] awid,
   input  logic [31:0]     awaddr,
   input  logic [3:0]      awlen,
   input  logic [2:0]      awsize,
   input  logic            awvalid,
   output logic            awready,
   input  logic [ID_W-1:0] wid,
   input  logic [31:0]     wdata,
   input  logic            wvalid,
   output logic            wready,
   output logic [ID_W-1:0] bid,
   output logic [1:0]      bresp,
   output logic            bvalid,
   input  logic            bready,
   input  logic [ID_W-1:0] arid,
   input  logic [31:0]     araddr,
   input  logic [3:0]      arlen,
   input  logic [2:0]      arsize,
   input  logic            arvalid,
   output logic            arready,
   output logic [ID_W-1:0] rid,
   output logic [31:0]     rdata,
   output logic [1:0]      rresp,
   output logic            rlast,
   output logic            rvalid,
   input  logic            rready
);

   sys_bus_if host_bus ();     // bridge to decoder
   sys_bus_if bank_a_bus ();
   sys_bus_if bank_b_bus ();

   axi_sys_bridge #(.ID_W(ID_W), .ACK_TIMEOUT(ACK_TIMEOUT)) u_bridge (
      .axi, .reset,
      .awid, .awaddr, .awlen, .awsize, .awvalid, .awready,
      .wid, .wdata, .wvalid, .wready,
      .bid, .bresp, .bvalid, .bready,
      .arid, .araddr, .arlen, .arsize, .arvalid, .arready,
      .rid, .rdata, .rresp, .rlast, .rvalid, .rready,
      .bus (host_bus.m)
   );

   sys_bus_decoder u_decoder (
      .axi, .reset,
      .host   (host_bus.s),
      .bank_a (bank_a_bus.m),
      .bank_b (bank_b_bus.m)
   );

   // bank a answers next cycle, bank b three cycles later
   reg_bank #(.BANK_ID(BANK_A_ID), .ACK_DELAY(0)) u_bank_a (.axi, .reset, .bus (bank_a_bus.s));
   reg_bank #(.BANK_ID(BANK_B_ID), .ACK_DELAY(3)) u_bank_b (.axi, .reset, .bus (bank_b_bus.s));

endmodule

//--- verif/axi_sys_tb.sv
// AXI bridge testbench

module axi_sys_tb import sys_bus_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int          ID_W        = 8;
   localparam int          ACK_TIMEOUT = 32;
   localparam logic [31:0] BANK_A_ID   = 32'h0a0a_1d00;
   localparam logic [31:0] BANK_B_ID   = 32'h0b0b_1d01;
   localparam int          NUM_TESTS   = 6;
   localparam int          WATCHDOG    = NUM_TESTS * (ACK_TIMEOUT + 20);   // in cycles
   localparam logic [2:0]  SIZE4       = 3'd2;                             // 4-byte beat

   logic            axi;
   logic            reset;
   logic [ID_W-1:0] awid;
   logic [31:0]     awaddr;
   logic [3:0]      awlen;
   logic [2:0]      awsize;
   logic            awvalid;
   logic            awready;
   logic [ID_W-1:0] wid;
   logic [31:0]     wdata;
   logic            wvalid;
   logic            wready;
   logic [ID_W-1:0] bid;
   logic [1:0]      bresp;
   logic            bvalid;
   logic            bready;
   logic [ID_W-1:0] arid;
   logic [31:0]     araddr;
   logic [3:0]      arlen;
   logic [2:0]      arsize;
   logic            arvalid;
   logic            arready;
   logic [ID_W-1:0] rid;
   logic [31:0]     rdata;
   logic [1:0]      rresp;
   logic            rlast;
   logic            rvalid;
   logic            rready;

   int              seed = 32'hb3a8_e579;
   int              errors = 0;
   int              errors_at_start = 0;
   int              test_no = 0;
   int              tests_failed = 0;
   int              cyc = 0;               // free-running cycle count
   int              hs_cyc = 0;            // cycle of last address handshake
   int              min_lat = 0;           // lower bound on response latency
   logic            started = 1'b0;        // first transfer issued
   logic            arb_test = 1'b0;
   logic            b_taken = 1'b0;        // write response done in arb test
   logic            check_rdata = 1'b0;
   axi_resp_e       exp_bresp = OKAY;
   axi_resp_e       exp_rresp = OKAY;
   logic [ID_W-1:0] exp_bid = '0;
   logic [ID_W-1:0] exp_rid = '0;
   logic [31:0]     exp_rdata = '0;
   logic [31:0]     ref_regs [0:1][1:3];   // model of both banks
   logic            aw_hs_q = 1'b0;
   logic            w_hs_q = 1'b0;
   logic            ar_hs_q = 1'b0;
   logic            b_hs_q = 1'b0;
   logic            r_hs_q = 1'b0;

   axi_sys_top #(
      .ID_W        (ID_W),
      .ACK_TIMEOUT (ACK_TIMEOUT),
      .BANK_A_ID   (BANK_A_ID),
      .BANK_B_ID   (BANK_B_ID)
   ) uut (.*);

   initial begin
      axi = 1'b0;
      forever #4 axi = ~axi;   // 8 ns period
   end

   // ------------------------------
   // handshake monitor

   always @(posedge axi) begin
      aw_hs_q <= awvalid && awready;   // seen by tasks at next negedge
      w_hs_q  <= wvalid && wready;
      ar_hs_q <= arvalid && arready;
      b_hs_q  <= bvalid && bready;
      r_hs_q  <= rvalid && rready;
      cyc     <= cyc + 1;
      if ((awvalid && awready) || (arvalid && arready)) hs_cyc <= cyc;
      if (arb_test && bvalid && bready) b_taken <= 1'b1;
   end

   // ------------------------------
   // checks

   idle_after_reset: assert property (@(posedge axi) disable iff (reset)
      !started |-> (!bvalid && !rvalid && !rlast && awready))
      else begin
         $display("%0t: outputs left the idle state before any transfer", $time);
         errors++;
      end
   ar_yields: assert property (@(posedge axi) disable iff (reset)
      awvalid |-> !arready)
      else begin
         $display("[FAIL] %0t arready got %0b expected 0", $time, $sampled(arready));
         errors++;
      end
   w_only_busy: assert property (@(posedge axi) disable iff (reset)
      !(wready && awready))
      else begin
         $display("%0t: wready was high while the bridge was idle", $time);
         errors++;
      end
   bresp_check: assert property (@(posedge axi) disable iff (reset)
      (bvalid && bready) |-> (bresp == exp_bresp))
      else begin
         $display("[FAIL] %0t bresp got %0h expected %0h", $time, $sampled(bresp),
                  $sampled(exp_bresp));
         errors++;
      end
   bid_check: assert property (@(posedge axi) disable iff (reset)
      (bvalid && bready) |-> (bid == exp_bid))
      else begin
         $display("[FAIL] %0t bid got %0h expected %0h", $time, $sampled(bid), $sampled(exp_bid));
         errors++;
      end
   rresp_check: assert property (@(posedge axi) disable iff (reset)
      (rvalid && rready) |-> (rresp == exp_rresp))
      else begin
         $display("[FAIL] %0t rresp got %0h expected %0h", $time, $sampled(rresp),
                  $sampled(exp_rresp));
         errors++;
      end
   rid_check: assert property (@(posedge axi) disable iff (reset)
      (rvalid && rready) |-> (rid == exp_rid))
      else begin
         $display("[FAIL] %0t rid got %0h expected %0h", $time, $sampled(rid), $sampled(exp_rid));
         errors++;
      end
   rdata_check: assert property (@(posedge axi) disable iff (reset)
      (rvalid && rready && check_rdata) |-> (rdata == exp_rdata))
      else begin
         $display("[FAIL] %0t rdata got %0h expected %0h", $time, $sampled(rdata),
                  $sampled(exp_rdata));
         errors++;
      end
   rlast_check: assert property (@(posedge axi) disable iff (reset) rlast == rvalid)
      else begin
         $display("[FAIL] %0t rlast got %0b expected %0b", $time, $sampled(rlast),
                  $sampled(rvalid));
         errors++;
      end
   b_hold: assert property (@(posedge axi) disable iff (reset)
      (bvalid && !bready) |=> (bvalid && $stable(bid) && $stable(bresp)))
      else begin
         $display("%0t: write response dropped or changed while bready was low", $time);
         errors++;
      end
   b_latency: assert property (@(posedge axi) disable iff (reset)
      $rose(bvalid) |-> (cyc - hs_cyc >= min_lat))
      else begin
         $display("%0t: write response came too early, only %0d cycles", $time,
                  $sampled(cyc - hs_cyc));
         errors++;
      end
   r_latency: assert property (@(posedge axi) disable iff (reset)
      $rose(rvalid) |-> (cyc - hs_cyc >= min_lat))
      else begin
         $display("%0t: read response came too early, only %0d cycles", $time,
                  $sampled(cyc - hs_cyc));
         errors++;
      end
   b_before_r: assert property (@(posedge axi) disable iff (reset)
      (arb_test && $rose(rvalid)) |-> b_taken)
      else begin
         $display("%0t: read response came before the competing write finished", $time);
         errors++;
      end

   // ------------------------------
   // stimulus helpers

   function automatic logic [31:0] reg_addr(input int bank, input int idx);
      return {4'(bank), 24'h0, 2'(idx), 2'b00};   // region, unused, index, offset
   endfunction

   function automatic logic [31:0] expected_word(input int bank, input int idx);
      if (idx == 0) return (bank == 0) ? BANK_A_ID : BANK_B_ID;
      return ref_regs[bank][idx];
   endfunction

   task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] len, input logic [2:0] size,
                             input axi_resp_e resp);
      logic            aw_done;
      logic            w_done;
      logic [ID_W-1:0] id;
      id        = ID_W'($random(seed));
      exp_bid   = id;
      exp_bresp = resp;
      started   = 1'b1;
      awid      = id;
      awaddr    = addr;
      awlen     = len;
      awsize    = size;
      awvalid   = 1'b1;
      wid       = id;
      wdata     = data;
      wvalid    = 1'b1;   // data offered with the address
      aw_done   = 1'b0;
      w_done    = 1'b0;
      while (!(aw_done && w_done)) begin
         @(negedge axi);
         if (aw_hs_q) begin
            aw_done = 1'b1;
            awvalid = 1'b0;
         end
         if (w_hs_q) begin
            w_done = 1'b1;
            wvalid = 1'b0;
         end
      end
      do @(negedge axi); while (!b_hs_q);
      // only accepted writes to a mapped data register change the model
      if (resp == OKAY && addr[31:28] < 4'd2 && addr[3:2] != 2'd0)
         ref_regs[int'(addr[28])][int'(addr[3:2])] = data;
   endtask

   task automatic await_read();
      do @(negedge axi); while (!ar_hs_q);
      arvalid = 1'b0;
      do @(negedge axi); while (!r_hs_q);
   endtask

   task automatic read_word(input logic [31:0] addr, input logic [3:0] len,
                            input logic [2:0] size, input axi_resp_e resp,
                            input logic chk, input logic [31:0] data);
      exp_rid     = ID_W'($random(seed));
      exp_rresp   = resp;
      exp_rdata   = data;
      check_rdata = chk;
      started     = 1'b1;
      arid        = exp_rid;
      araddr      = addr;
      arlen       = len;
      arsize      = size;
      arvalid     = 1'b1;
      await_read();
   endtask

   task automatic finish_test(input string name);
      int n;
      n = errors - errors_at_start;
      test_no++;
      if (n == 0) begin
         $display("test %0d %s: pass", test_no, name);
      end else begin
         $display("test %0d %s: failed with %0d errors", test_no, name, n);
         tests_failed++;
      end
      errors_at_start = errors;
   endtask

   // ------------------------------
   // watchdog

   initial begin
      @(negedge reset);
      repeat (WATCHDOG) @(posedge axi);
      $display("watchdog expired after %0d cycles, run stopped", WATCHDOG);
      $display("Test failures found");
      $finish;
   end

   // ------------------------------
   // test sequence

   initial begin
      logic [31:0] data;
      reset   = 1'b1;
      awid    = '0;
      awaddr  = '0;
      awlen   = '0;
      awsize  = SIZE4;
      awvalid = 1'b0;
      wid     = '0;
      wdata   = '0;
      wvalid  = 1'b0;
      bready  = 1'b1;
      arid    = '0;
      araddr  = '0;
      arlen   = '0;
      arsize  = SIZE4;
      arvalid = 1'b0;
      rready  = 1'b1;
      for (int b = 0; b < 2; b++)
         for (int i = 1; i <= 3; i++) ref_regs[b][i] = 32'h0;   // bank reset value
      repeat (16) @(posedge axi);
      @(negedge axi);
      reset = 1'b0;

      repeat (4) @(negedge axi);   // idle outputs watched here
      finish_test("reset state");

      for (int b = 0; b < 2; b++) begin
         for (int i = 1; i <= 3; i++) begin
            data = $random(seed);
            write_word(reg_addr(b, i), data, 4'd0, SIZE4, OKAY);
         end
         for (int i = 1; i <= 3; i++)
            read_word(reg_addr(b, i), 4'd0, SIZE4, OKAY, 1'b1, expected_word(b, i));
         if (b == 0) finish_test("bank a write and read back");
      end
      for (int b = 0; b < 2; b++) begin
         data = $random(seed);
         write_word(reg_addr(b, 0), data, 4'd0, SIZE4, OKAY);   // id word ignores it
         read_word(reg_addr(b, 0), 4'd0, SIZE4, OKAY, 1'b1, expected_word(b, 0));
      end
      finish_test("bank b and id words");

      min_lat = ACK_TIMEOUT;   // no bank answers, bridge must time out
      data    = $random(seed);
      write_word(32'h5000_0004, data, 4'd0, SIZE4, SLVERR);
      read_word(32'hc000_0008, 4'd0, SIZE4, SLVERR, 1'b0, 32'h0);
      min_lat = 0;
      finish_test("unmapped region timeout");

      data = $random(seed);
      write_word(reg_addr(0, 2), data, 4'd1, SIZE4, SLVERR);   // burst
      data = $random(seed);
      write_word(reg_addr(1, 3), data, 4'd0, 3'd1, SLVERR);    // 2-byte size
      read_word(reg_addr(0, 1), 4'd2, SIZE4, SLVERR, 1'b0, 32'h0);
      read_word(reg_addr(1, 1), 4'd0, 3'd3, SLVERR, 1'b0, 32'h0);
      read_word(reg_addr(0, 2), 4'd0, SIZE4, OKAY, 1'b1, expected_word(0, 2));
      read_word(reg_addr(1, 3), 4'd0, SIZE4, OKAY, 1'b1, expected_word(1, 3));
      finish_test("protocol errors");

      data        = $random(seed);
      arb_test    = 1'b1;
      bready      = 1'b0;            // stall the write response
      exp_rid     = ID_W'($random(seed));
      exp_rresp   = OKAY;
      exp_rdata   = data;            // write wins, read sees new value
      check_rdata = 1'b1;
      arid        = exp_rid;
      araddr      = reg_addr(0, 1);
      arlen       = 4'd0;
      arsize      = SIZE4;
      arvalid     = 1'b1;            // same cycle as awvalid
      fork
         write_word(reg_addr(0, 1), data, 4'd0, SIZE4, OKAY);
         begin
            do @(negedge axi); while (!bvalid);
            repeat (3) @(negedge axi);
            bready = 1'b1;
         end
      join
      await_read();
      arb_test = 1'b0;
      finish_test("arbitration and back-pressure");

      repeat (2) @(negedge axi);
      $display("%0d tests run, %0d failed, %0d check errors", test_no, tests_failed, errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

//--- build.f
verilog/sys_bus_pkg.sv
verilog/sys_bus_if.sv
verilog/axi_sys_bridge.sv
verilog/sys_bus_decoder.sv
verilog/reg_bank.sv
verilog/axi_sys_top.sv
verif/axi_sys_tb.sv

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of the AXI bridge testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module axi_sys_tb \
   -f build.f \
   -o axi_sys_sim

out=$(./obj_dir/axi_sys_sim)
echo "$out"

if echo "$out" | grep -q 'All tests passed!'; then
   exit 0
fi
exit 1
